/* logic/scpad_macros.svh */
`ifndef SCPAD_MACROS_SVH
`define SCPAD_MACROS_SVH

// number of column banks and the width of one bank word.
`define NUM_COLS      4
`define DATA_W        32

// each bank holds 2**ROW_IDX_WIDTH rows.
`define ROW_IDX_WIDTH 4

// bank read latency, and the delay from write issue to its done pulse.
`define READ_LATENCY  2
`define WRITE_LATENCY 4

`endif

/* logic/scpad_geom_pkg.sv */
`default_nettype none

`include "scpad_macros.svh"

package scpad_geom_pkg;

    typedef logic [`ROW_IDX_WIDTH-1:0] row_idx_t;
    typedef logic [`NUM_COLS-1:0]      col_mask_t;

    // column start and count for partial-row frontend accesses.
    typedef logic [$clog2(`NUM_COLS)-1:0] col_idx_t;
    typedef logic [$clog2(`NUM_COLS):0]   col_cnt_t;

    typedef logic [`DATA_W-1:0]                 word_t;
    typedef logic [`NUM_COLS-1:0][`DATA_W-1:0]  row_data_t;

endpackage

`default_nettype wire

/* logic/scpad_req_pkg.sv */
`default_nettype none

package scpad_req_pkg;
    import scpad_geom_pkg::*;

    // tag that names the requester a response belongs to.
    typedef enum logic {
        SRC_FE = 1'b0,
        SRC_BE = 1'b1
    } src_t;

    typedef struct packed {
        logic      valid;
        src_t      src;
        row_idx_t  row;
        col_mask_t col_mask;
    } sram_r_req_t;

    typedef struct packed {
        logic      valid;
        src_t      src;
        row_idx_t  row;
        col_mask_t col_mask;
        row_data_t wdata;
    } sram_w_req_t;

    typedef struct packed {
        logic      valid;
        src_t      src;
        row_data_t rdata;
    } sram_r_res_t;

    typedef struct packed {
        logic done;
        src_t src;
    } sram_w_res_t;

endpackage

`default_nettype wire

/* logic/scpad_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface scpad_port_if;
    import scpad_req_pkg::*;

    // request side, driven by the requester port.
    sram_r_req_t r_req;
    sram_w_req_t w_req;

    // grant and response side, driven by the controller.
    logic        r_grant;
    logic        w_grant;
    sram_r_res_t r_res;
    sram_w_res_t w_res;

    modport port (
        output r_req,
        output w_req,
        input  r_grant,
        input  w_grant,
        input  r_res,
        input  w_res
    );

    modport ctrl (
        input  r_req,
        input  w_req,
        output r_grant,
        output w_grant,
        output r_res,
        output w_res
    );

endinterface

`default_nettype wire

/* logic/req_arb.sv */
`timescale 1ns/1ps
`default_nettype none

module req_arb #(
    parameter type req_t = scpad_req_pkg::sram_r_req_t
) (
    input  req_t hi_req,
    input  req_t lo_req,
    output req_t win,
    output logic lo_grant
);

    // fixed priority; the high side is never refused.
    always_comb begin
        if (hi_req.valid) begin
            win = hi_req;
        end else begin
            win = lo_req;
        end
    end

    // the low requester holds its request until it sees this grant.
    assign lo_grant = lo_req.valid && !hi_req.valid;

endmodule

`default_nettype wire

/* logic/fe_port.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_port (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      rd,
    input  logic                      wr,
    input  scpad_geom_pkg::row_idx_t  row,
    input  scpad_geom_pkg::col_idx_t  col_start,
    input  scpad_geom_pkg::col_cnt_t  col_count,
    input  scpad_geom_pkg::row_data_t wdata,
    output logic                      rd_valid,
    output scpad_geom_pkg::row_data_t rdata,
    output logic                      wr_done,
    scpad_port_if.port                port
);
    import scpad_geom_pkg::*;
    import scpad_req_pkg::*;

    logic      rd_q;
    logic      wr_q;
    row_idx_t  row_q;
    col_mask_t mask;
    col_mask_t mask_q;
    row_data_t wdata_q;

    // contiguous run of columns from col_start, so anything past the last bank falls away.
    always_comb begin
        for (int i = 0; i < $bits(col_mask_t); i++) begin
            mask[i] = (i >= int'(col_start)) && (i < int'(col_start) + int'(col_count));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else begin
            rd_q <= rd;
            wr_q <= wr;
        end
    end

    always_ff @(posedge clk) begin
        row_q   <= row;
        mask_q  <= mask;
        wdata_q <= wdata;
    end

    // the frontend always wins arbitration, so its requests last one cycle.
    assign port.r_req = '{valid: rd_q, src: SRC_FE, row: row_q, col_mask: mask_q};
    assign port.w_req = '{valid: wr_q, src: SRC_FE, row: row_q,
                          col_mask: mask_q, wdata: wdata_q};

    assign rd_valid = port.r_res.valid;
    assign rdata    = port.r_res.rdata;
    assign wr_done  = port.w_res.done;

endmodule

`default_nettype wire

/* logic/be_port.sv */
`timescale 1ns/1ps
`default_nettype none

module be_port (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      rd,
    input  logic                      wr,
    input  scpad_geom_pkg::row_idx_t  row,
    input  scpad_geom_pkg::row_data_t wdata,
    output logic                      rd_busy,
    output logic                      wr_busy,
    output logic                      rd_valid,
    output scpad_geom_pkg::row_data_t rdata,
    output logic                      wr_done,
    scpad_port_if.port                port
);
    import scpad_geom_pkg::*;
    import scpad_req_pkg::*;

    logic      rd_q;
    logic      wr_q;
    row_idx_t  rd_row_q;
    row_idx_t  wr_row_q;
    row_data_t wdata_q;
    logic      rd_accept;
    logic      wr_accept;

    // ==================================================
    // deferral slots
    // ==================================================

    // a slot is busy while its request waits for the arbiter.
    // A slot granted this cycle is free for a new strobe.
    assign rd_busy   = rd_q && !port.r_grant;
    assign wr_busy   = wr_q && !port.w_grant;
    assign rd_accept = rd && !rd_busy;
    assign wr_accept = wr && !wr_busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else begin
            rd_q <= rd_accept || rd_busy;
            wr_q <= wr_accept || wr_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_row_q <= row;
        end
        if (wr_accept) begin
            wr_row_q <= row;
            wdata_q  <= wdata;
        end
    end

    // ==================================================
    // requests and responses
    // ==================================================

    // the DMA side always moves whole rows.
    assign port.r_req = '{valid: rd_q, src: SRC_BE, row: rd_row_q, col_mask: '1};
    assign port.w_req = '{valid: wr_q, src: SRC_BE, row: wr_row_q,
                          col_mask: '1, wdata: wdata_q};

    assign rd_valid = port.r_res.valid;
    assign rdata    = port.r_res.rdata;
    assign wr_done  = port.w_res.done;

endmodule

`default_nettype wire

/* logic/sram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scpad_macros.svh"

module sram_ctrl (
    input  logic                      clk,
    input  logic                      arst_n,
    scpad_port_if.ctrl                fe,
    scpad_port_if.ctrl                be,
    output scpad_geom_pkg::col_mask_t ren,
    output scpad_geom_pkg::col_mask_t wen,
    output scpad_geom_pkg::row_idx_t  raddr,
    output scpad_geom_pkg::row_idx_t  waddr,
    output scpad_geom_pkg::row_data_t wdata,
    input  scpad_geom_pkg::col_mask_t rdone,
    input  scpad_geom_pkg::col_mask_t wdone,
    input  scpad_geom_pkg::row_data_t rdata
);
    import scpad_geom_pkg::*;
    import scpad_req_pkg::*;

    sram_r_req_t r_win;
    sram_w_req_t w_win;
    logic        be_r_grant;
    logic        be_w_grant;
    src_t        r_src_q [`READ_LATENCY];
    src_t        w_src_q [`WRITE_LATENCY];
    logic [1:0]  r_vld_q;
    logic [1:0]  w_done_q;
    row_data_t   rdata_q;

    // ==================================================
    // arbitration and bank drive
    // ==================================================

    req_arb #(.req_t(sram_r_req_t)) u_r_arb (
        .hi_req   (fe.r_req),
        .lo_req   (be.r_req),
        .win      (r_win),
        .lo_grant (be_r_grant)
    );

    req_arb #(.req_t(sram_w_req_t)) u_w_arb (
        .hi_req   (fe.w_req),
        .lo_req   (be.w_req),
        .win      (w_win),
        .lo_grant (be_w_grant)
    );

    assign fe.r_grant = fe.r_req.valid;
    assign fe.w_grant = fe.w_req.valid;
    assign be.r_grant = be_r_grant;
    assign be.w_grant = be_w_grant;

    assign ren   = r_win.valid ? r_win.col_mask : '0;
    assign wen   = w_win.valid ? w_win.col_mask : '0;
    assign raddr = r_win.row;
    assign waddr = w_win.row;
    assign wdata = w_win.wdata;

    // ==================================================
    // tag pipelines and response routing
    // ==================================================

    // the tags step in lockstep with the banks, so the last stage matches rdone and wdone.
    always_ff @(posedge clk) begin
        r_src_q[0] <= r_win.src;
        w_src_q[0] <= w_win.src;
        for (int i = 1; i < `READ_LATENCY; i++) begin
            r_src_q[i] <= r_src_q[i-1];
        end
        for (int i = 1; i < `WRITE_LATENCY; i++) begin
            w_src_q[i] <= w_src_q[i-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r_vld_q  <= '0;
            w_done_q <= '0;
        end else begin
            r_vld_q  <= '0;
            w_done_q <= '0;
            if (|rdone) begin
                r_vld_q[r_src_q[`READ_LATENCY-1]] <= 1'b1;
            end
            if (|wdone) begin
                w_done_q[w_src_q[`WRITE_LATENCY-1]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|rdone) begin
            rdata_q <= rdata;
        end
    end

    assign fe.r_res = '{valid: r_vld_q[SRC_FE], src: SRC_FE, rdata: rdata_q};
    assign be.r_res = '{valid: r_vld_q[SRC_BE], src: SRC_BE, rdata: rdata_q};
    assign fe.w_res = '{done: w_done_q[SRC_FE], src: SRC_FE};
    assign be.w_res = '{done: w_done_q[SRC_BE], src: SRC_BE};

endmodule

`default_nettype wire

/* logic/sram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scpad_macros.svh"

module sram_bank #(
    parameter int READ_LATENCY  = `READ_LATENCY,
    parameter int WRITE_LATENCY = `WRITE_LATENCY
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     ren,
    input  logic                     wen,
    input  scpad_geom_pkg::row_idx_t raddr,
    input  scpad_geom_pkg::row_idx_t waddr,
    input  scpad_geom_pkg::word_t    wdata,
    output scpad_geom_pkg::word_t    rdata,
    output logic                     rdone,
    output logic                     wdone
);
    import scpad_geom_pkg::*;

    localparam int DEPTH = 1 << `ROW_IDX_WIDTH;

    word_t                    mem [DEPTH];
    word_t                    rd_data_q [READ_LATENCY];
    logic [READ_LATENCY-1:0]  rd_vld_q;
    logic [WRITE_LATENCY-1:0] wr_vld_q;

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
        rd_data_q[0] <= mem[raddr];
        for (int i = 1; i < READ_LATENCY; i++) begin
            rd_data_q[i] <= rd_data_q[i-1];
        end
    end

    // one valid bit per stage keeps the bank fully pipelined.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_vld_q <= '0;
            wr_vld_q <= '0;
        end else begin
            rd_vld_q <= (rd_vld_q << 1) | READ_LATENCY'(ren);
            wr_vld_q <= (wr_vld_q << 1) | WRITE_LATENCY'(wen);
        end
    end

    assign rdone = rd_vld_q[READ_LATENCY-1];
    assign wdone = wr_vld_q[WRITE_LATENCY-1];
    // An idle bank drives zero, so a partial read returns zero in its unread columns.
    assign rdata = rdone ? rd_data_q[READ_LATENCY-1] : '0;

endmodule

`default_nettype wire

/* logic/scratchpad.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scpad_macros.svh"

module scratchpad (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      fe_rd,
    input  logic                      fe_wr,
    input  scpad_geom_pkg::row_idx_t  fe_row,
    input  scpad_geom_pkg::col_idx_t  fe_col_start,
    input  scpad_geom_pkg::col_cnt_t  fe_col_count,
    input  scpad_geom_pkg::row_data_t fe_wdata,
    output logic                      fe_rd_valid,
    output scpad_geom_pkg::row_data_t fe_rdata,
    output logic                      fe_wr_done,
    input  logic                      be_rd,
    input  logic                      be_wr,
    input  scpad_geom_pkg::row_idx_t  be_row,
    input  scpad_geom_pkg::row_data_t be_wdata,
    output logic                      be_rd_busy,
    output logic                      be_wr_busy,
    output logic                      be_rd_valid,
    output scpad_geom_pkg::row_data_t be_rdata,
    output logic                      be_wr_done
);
    import scpad_geom_pkg::*;

    col_mask_t ren;
    col_mask_t wen;
    col_mask_t rdone;
    col_mask_t wdone;
    row_idx_t  raddr;
    row_idx_t  waddr;
    row_data_t bank_wdata;
    row_data_t bank_rdata;

    scpad_port_if fe_if ();
    scpad_port_if be_if ();

    // ==================================================
    // requester ports and controller
    // ==================================================

    fe_port u_fe_port (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd        (fe_rd),
        .wr        (fe_wr),
        .row       (fe_row),
        .col_start (fe_col_start),
        .col_count (fe_col_count),
        .wdata     (fe_wdata),
        .rd_valid  (fe_rd_valid),
        .rdata     (fe_rdata),
        .wr_done   (fe_wr_done),
        .port      (fe_if.port)
    );

    be_port u_be_port (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd       (be_rd),
        .wr       (be_wr),
        .row      (be_row),
        .wdata    (be_wdata),
        .rd_busy  (be_rd_busy),
        .wr_busy  (be_wr_busy),
        .rd_valid (be_rd_valid),
        .rdata    (be_rdata),
        .wr_done  (be_wr_done),
        .port     (be_if.port)
    );

    sram_ctrl u_sram_ctrl (
        .clk    (clk),
        .arst_n (arst_n),
        .fe     (fe_if.ctrl),
        .be     (be_if.ctrl),
        .ren    (ren),
        .wen    (wen),
        .raddr  (raddr),
        .waddr  (waddr),
        .wdata  (bank_wdata),
        .rdone  (rdone),
        .wdone  (wdone),
        .rdata  (bank_rdata)
    );

    // ==================================================
    // bank array
    // ==================================================

    // every bank sees the same row address and owns one word of the row.
    for (genvar gi = 0; gi < `NUM_COLS; gi++) begin : g_bank
        sram_bank #(
            .READ_LATENCY  (`READ_LATENCY),
            .WRITE_LATENCY (`WRITE_LATENCY)
        ) u_bank (
            .clk    (clk),
            .arst_n (arst_n),
            .ren    (ren[gi]),
            .wen    (wen[gi]),
            .raddr  (raddr),
            .waddr  (waddr),
            .wdata  (bank_wdata[gi]),
            .rdata  (bank_rdata[gi]),
            .rdone  (rdone[gi]),
            .wdone  (wdone[gi])
        );
    end

endmodule

`default_nettype wire

/* verif/scratchpad_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scpad_macros.svh"

module scratchpad_tb;
    import scpad_geom_pkg::*;

    localparam int       TIMEOUT   = 40;
    localparam int       ROWS      = 1 << `ROW_IDX_WIDTH;
    localparam int       RD_CYC    = `READ_LATENCY + 2;
    localparam int       WR_CYC    = `WRITE_LATENCY + 2;
    localparam int       W_FE_RD   = 0;
    localparam int       W_FE_WR   = 1;
    localparam int       W_BE_RD   = 2;
    localparam int       W_BE_WR   = 3;
    localparam col_cnt_t FULL      = col_cnt_t'(`NUM_COLS);

    logic      clk = 1'b0;
    logic      arst_n;
    logic      fe_rd;
    logic      fe_wr;
    row_idx_t  fe_row;
    col_idx_t  fe_col_start;
    col_cnt_t  fe_col_count;
    row_data_t fe_wdata;
    logic      fe_rd_valid;
    row_data_t fe_rdata;
    logic      fe_wr_done;
    logic      be_rd;
    logic      be_wr;
    row_idx_t  be_row;
    row_data_t be_wdata;
    logic      be_rd_busy;
    logic      be_wr_busy;
    logic      be_rd_valid;
    row_data_t be_rdata;
    logic      be_wr_done;

    logic [31:0]     lfsr = 32'h1c0f_1a17;
    row_data_t       model [ROWS];
    logic [ROWS-1:0] written = '0;
    int              data_errs = 0;
    int              ctrl_errs = 0;
    int              timeouts = 0;
    int              fe_done_cnt = 0;
    int              be_done_cnt = 0;

    scratchpad i_dut (.*);

    always #5 clk = ~clk;

    // done pulses are counted per port so that extra or missing pulses show up.
    always @(negedge clk) begin
        if (fe_wr_done === 1'b1) begin
            fe_done_cnt++;
        end
        if (be_wr_done === 1'b1) begin
            be_done_cnt++;
        end
    end

    // ==================================================
    // random data and expected values
    // ==================================================

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_row(output row_data_t r);
        logic [$bits(row_data_t)-1:0] flat;
        for (int i = 0; i < $bits(row_data_t); i++) begin
            lfsr    = lfsr_step(lfsr);
            flat[i] = lfsr[0];
        end
        r = flat;
    endtask

    // columns from start onward, count of them, and none past the last bank.
    function automatic row_data_t merge_row(input row_data_t old, input row_data_t data,
                                            input col_idx_t start, input col_cnt_t count);
        row_data_t r;
        r = old;
        for (int c = 0; c < `NUM_COLS; c++) begin
            if (c >= int'(start) && c - int'(start) < int'(count)) begin
                r[c] = data[c];
            end
        end
        return r;
    endfunction

    // ==================================================
    // checks
    // ==================================================

    task automatic check_row(input string what, input row_data_t got, input row_data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("ERR %0t: %s returned %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            ctrl_errs++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            ctrl_errs++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    endtask

    // ==================================================
    // drivers
    // ==================================================

    // returns on the edge that samples the strobe, which counts as cycle 0.
    task automatic fe_issue(input logic rd, input logic wr, input row_idx_t row,
                            input col_idx_t start, input col_cnt_t count, input row_data_t data);
        @(posedge clk);
        fe_rd        <= rd;
        fe_wr        <= wr;
        fe_row       <= row;
        fe_col_start <= start;
        fe_col_count <= count;
        fe_wdata     <= data;
        @(posedge clk);
        fe_rd <= 1'b0;
        fe_wr <= 1'b0;
    endtask

    // only used while the backend channel is idle, so the strobe is never dropped.
    task automatic be_issue(input logic rd, input logic wr, input row_idx_t row,
                            input row_data_t data);
        @(posedge clk);
        be_rd    <= rd;
        be_wr    <= wr;
        be_row   <= row;
        be_wdata <= data;
        @(posedge clk);
        be_rd <= 1'b0;
        be_wr <= 1'b0;
    endtask

    // the first negedge after the sampling edge already lies in cycle 1.
    task automatic wait_resp(input int which, input string what, output int cycles,
                             output row_data_t data);
        logic hit;
        hit    = 1'b0;
        cycles = 1;
        data   = '0;
        while (!hit && cycles <= TIMEOUT) begin
            @(negedge clk);
            case (which)
                W_FE_RD: hit = fe_rd_valid;
                W_FE_WR: hit = fe_wr_done;
                W_BE_RD: hit = be_rd_valid;
                default: hit = be_wr_done;
            endcase
            if (!hit) begin
                cycles++;
            end
        end
        if (hit) begin
            data = (which == W_BE_RD) ? be_rdata : fe_rdata;
        end else begin
            report_timeout(what);
        end
    endtask

    // ==================================================
    // tests
    // ==================================================

    task automatic test_reset_levels();
        @(negedge clk);
        check_level("fe_rd_valid after reset", fe_rd_valid, 1'b0);
        check_level("fe_wr_done after reset", fe_wr_done, 1'b0);
        check_level("be_rd_valid after reset", be_rd_valid, 1'b0);
        check_level("be_wr_done after reset", be_wr_done, 1'b0);
        check_level("be_rd_busy after reset", be_rd_busy, 1'b0);
        check_level("be_wr_busy after reset", be_wr_busy, 1'b0);
    endtask

    task automatic test_fe_full_row();
        row_data_t data;
        row_data_t got;
        int        cyc;
        rand_row(data);
        fe_issue(1'b0, 1'b1, row_idx_t'(1), '0, FULL, data);
        model[1]   = data;
        written[1] = 1'b1;
        wait_resp(W_FE_WR, "frontend write done", cyc, got);
        check_count("frontend write done cycle", cyc, WR_CYC);
        fe_issue(1'b1, 1'b0, row_idx_t'(1), '0, FULL, '0);
        wait_resp(W_FE_RD, "frontend read valid", cyc, got);
        check_count("frontend read valid cycle", cyc, RD_CYC);
        check_row("frontend full read", got, model[1]);
    endtask

    task automatic test_fe_partial_write();
        row_data_t data;
        row_data_t got;
        int        cyc;
        rand_row(data);
        // start 2 with count 3 runs past the last bank and is clipped to columns 2 and 3.
        fe_issue(1'b0, 1'b1, row_idx_t'(1), col_idx_t'(2), col_cnt_t'(3), data);
        model[1] = merge_row(model[1], data, col_idx_t'(2), col_cnt_t'(3));
        wait_resp(W_FE_WR, "partial write done", cyc, got);
        be_issue(1'b1, 1'b0, row_idx_t'(1), '0);
        wait_resp(W_BE_RD, "backend read valid", cyc, got);
        check_count("backend read valid cycle", cyc, RD_CYC);
        check_row("backend read after partial write", got, model[1]);
    endtask

    task automatic test_fe_partial_read();
        row_data_t got;
        int        cyc;
        fe_issue(1'b1, 1'b0, row_idx_t'(1), col_idx_t'(1), col_cnt_t'(2), '0);
        wait_resp(W_FE_RD, "partial read valid", cyc, got);
        check_row("frontend partial read", got,
                  merge_row('0, model[1], col_idx_t'(1), col_cnt_t'(2)));
    endtask

    // both ports strobe in one cycle; the backend loses once and finishes one cycle later.
    task automatic test_concurrent(input logic is_read, input row_idx_t fe_r,
                                   input row_idx_t be_r);
        row_data_t fe_data;
        row_data_t be_data;
        row_data_t fe_got;
        row_data_t be_got;
        int        cyc;
        int        fe_cyc;
        int        be_cyc;
        logic      saw_busy;
        logic      busy;
        fe_data  = '0;
        be_data  = '0;
        fe_got   = '0;
        be_got   = '0;
        fe_cyc   = -1;
        be_cyc   = -1;
        cyc      = 1;
        saw_busy = 1'b0;
        busy     = 1'b0;
        if (!is_read) begin
            rand_row(fe_data);
            rand_row(be_data);
            model[fe_r]   = fe_data;
            model[be_r]   = be_data;
            written[fe_r] = 1'b1;
            written[be_r] = 1'b1;
        end
        @(posedge clk);
        fe_rd        <= is_read;
        fe_wr        <= !is_read;
        fe_row       <= fe_r;
        fe_col_start <= '0;
        fe_col_count <= FULL;
        fe_wdata     <= fe_data;
        be_rd        <= is_read;
        be_wr        <= !is_read;
        be_row       <= be_r;
        be_wdata     <= be_data;
        @(posedge clk);
        fe_rd <= 1'b0;
        fe_wr <= 1'b0;
        be_rd <= 1'b0;
        be_wr <= 1'b0;
        while ((fe_cyc < 0 || be_cyc < 0) && cyc <= TIMEOUT) begin
            @(negedge clk);
            busy     = is_read ? be_rd_busy : be_wr_busy;
            saw_busy = saw_busy | busy;
            if ((is_read ? fe_rd_valid : fe_wr_done) && fe_cyc < 0) begin
                fe_cyc = cyc;
                fe_got = fe_rdata;
            end
            if ((is_read ? be_rd_valid : be_wr_done) && be_cyc < 0) begin
                be_cyc = cyc;
                be_got = be_rdata;
            end
            cyc++;
        end
        if (fe_cyc < 0 || be_cyc < 0) begin
            report_timeout("concurrent responses");
        end
        check_level("backend busy raised", saw_busy, 1'b1);
        check_level("backend busy released", busy, 1'b0);
        check_count("concurrent frontend cycle", fe_cyc, is_read ? RD_CYC : WR_CYC);
        check_count("concurrent backend cycle", be_cyc, (is_read ? RD_CYC : WR_CYC) + 1);
        if (is_read) begin
            check_row("concurrent frontend read", fe_got, model[fe_r]);
            check_row("concurrent backend read", be_got, model[be_r]);
        end
    endtask

    task automatic test_back_to_back();
        row_data_t fe_data [4];
        row_data_t be_data [4];
        int        fe_i;
        int        be_i;
        int        cyc;
        for (int k = 0; k < 4; k++) begin
            rand_row(fe_data[k]);
            rand_row(be_data[k]);
        end
        @(posedge clk);
        fe_done_cnt = 0;
        be_done_cnt = 0;
        fe_i        = 0;
        be_i        = 0;
        cyc         = 0;
        // the frontend writes rows 4 to 7 every cycle; the backend writes rows 8 to 11
        // and holds each strobe until it sees the channel free.
        while ((fe_i < 4 || be_i < 4) && cyc <= TIMEOUT) begin
            @(posedge clk);
            fe_wr <= (fe_i < 4);
            be_wr <= (be_i < 4);
            if (fe_i < 4) begin
                fe_row       <= row_idx_t'(4 + fe_i);
                fe_col_start <= '0;
                fe_col_count <= FULL;
                fe_wdata     <= fe_data[fe_i];
            end
            if (be_i < 4) begin
                be_row   <= row_idx_t'(8 + be_i);
                be_wdata <= be_data[be_i];
            end
            @(negedge clk);
            if (fe_wr) begin
                model[4 + fe_i]   = fe_data[fe_i];
                written[4 + fe_i] = 1'b1;
                fe_i++;
            end
            if (be_wr && !be_wr_busy) begin
                model[8 + be_i]   = be_data[be_i];
                written[8 + be_i] = 1'b1;
                be_i++;
            end
            cyc++;
        end
        @(posedge clk);
        fe_wr <= 1'b0;
        be_wr <= 1'b0;
        if (fe_i < 4 || be_i < 4) begin
            report_timeout("back-to-back write issue");
        end
        cyc = 0;
        while ((fe_done_cnt < 4 || be_done_cnt < 4) && cyc <= TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        if (cyc > TIMEOUT) begin
            report_timeout("back-to-back write dones");
        end
        repeat (10) @(posedge clk);
        check_count("frontend write dones", fe_done_cnt, 4);
        check_count("backend write dones", be_done_cnt, 4);
    endtask

    // odd rows go through the backend, even rows through the frontend.
    task automatic test_readback();
        row_data_t got;
        int        cyc;
        for (int r = 0; r < ROWS; r++) begin
            if (written[r]) begin
                if (r % 2 == 1) begin
                    be_issue(1'b1, 1'b0, row_idx_t'(r), '0);
                    wait_resp(W_BE_RD, "backend readback", cyc, got);
                end else begin
                    fe_issue(1'b1, 1'b0, row_idx_t'(r), '0, FULL, '0);
                    wait_resp(W_FE_RD, "frontend readback", cyc, got);
                end
                check_row($sformatf("readback of row %0d", r), got, model[r]);
            end
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        arst_n       = 1'b0;
        fe_rd        = 1'b0;
        fe_wr        = 1'b0;
        fe_row       = '0;
        fe_col_start = '0;
        fe_col_count = '0;
        fe_wdata     = '0;
        be_rd        = 1'b0;
        be_wr        = 1'b0;
        be_row       = '0;
        be_wdata     = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        test_reset_levels();
        test_fe_full_row();
        test_fe_partial_write();
        test_fe_partial_read();
        test_concurrent(1'b0, row_idx_t'(3), row_idx_t'(12));
        test_concurrent(1'b1, row_idx_t'(12), row_idx_t'(3));
        test_back_to_back();
        test_readback();
        $display("errors: data %0d, control %0d, timeouts %0d", data_errs, ctrl_errs, timeouts);
        if (data_errs + ctrl_errs + timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+logic
logic/scpad_geom_pkg.sv
logic/scpad_req_pkg.sv
logic/scpad_port_if.sv
logic/req_arb.sv
logic/fe_port.sv
logic/be_port.sv
logic/sram_ctrl.sv
logic/sram_bank.sv
logic/scratchpad.sv
verif/scratchpad_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing -f src.f --top-module scratchpad_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vscratchpad_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
